// File: common/color_pkg.sv
`default_nettype none

package color_pkg;

  typedef logic [7:0] intensity_t;

  typedef struct packed {
    intensity_t red;
    intensity_t green;
    intensity_t blue;
  } rgb888_t;

  // One on/off bit per channel, as driven onto the panel
  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_bits_t;

  // Channel is lit while the PWM level sits below its intensity
  function automatic rgb_bits_t pwm_bits(rgb888_t px, intensity_t level);
    rgb_bits_t bits;
    bits.r = (level < px.red);
    bits.g = (level < px.green);
    bits.b = (level < px.blue);
    return bits;
  endfunction

endpackage

`default_nettype wire

// File: common/panel_pkg.sv
`default_nettype none

package panel_pkg;

  localparam int NUM_COLS      = 32;
  localparam int NUM_SCAN_ROWS = 8;  // 1/8 scan with both halves shifted together

  typedef logic [3:0] row_t;
  typedef logic [4:0] col_t;
  typedef logic [2:0] scan_row_t;
  typedef logic [7:0] pwm_level_t;

  // {half, scan row, column}
  typedef logic [8:0] fb_addr_t;

  // Low bits select the scan row, upper bits the PWM level
  typedef logic [10:0] phase_t;

  typedef struct packed {
    row_t                 row;
    col_t                 col;
    color_pkg::rgb888_t   color;
    logic                 write;
  } pixel_write_t;

  typedef struct packed {
    scan_row_t            addr;
    color_pkg::rgb_bits_t rgb_top;
    color_pkg::rgb_bits_t rgb_bottom;
    logic                 lat;
    logic                 sclk;
  } hub75_t;

endpackage

`default_nettype wire

// File: verilog/frame_buffer.sv
`default_nettype none

module frame_buffer (
  input  logic                clk,
  input  logic                wr_en,
  input  panel_pkg::fb_addr_t wr_addr,
  input  color_pkg::rgb888_t  wr_data,
  input  panel_pkg::fb_addr_t rd_addr,
  output color_pkg::rgb888_t  rd_data
);

  import panel_pkg::*;
  import color_pkg::*;

  localparam int DEPTH = 2 ** $bits(fb_addr_t);

  // Top half in the lower 256 words, bottom half above
  rgb888_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read during write to the same word returns the old pixel
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  a_wr_addr_known: assert property (
    @(posedge clk) wr_en |-> !$isunknown(wr_addr)
  ) else $error("frame_buffer: write with unknown address %h", wr_addr);

endmodule

`default_nettype wire

// File: hub75_scan/shift_clock_gen.sv
`default_nettype none

module shift_clock_gen #(
  parameter int CLK_DIV = 6
) (
  input  logic            clk,
  input  logic            rst_n,
  output logic            sclk,
  output panel_pkg::col_t col,
  output logic            col_advance
);

  import panel_pkg::*;

  localparam int CNT_W = $clog2(CLK_DIV);

  logic [CNT_W-1:0] div_cnt;
  logic             toggle;

  assign toggle = (div_cnt == CNT_W'(CLK_DIV - 1));

  // sclk, column count and strobe all move on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt     <= '0;
      sclk        <= 1'b0;
      col         <= '0;
      col_advance <= 1'b0;
    end else begin
      col_advance <= 1'b0;
      if (toggle) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (!sclk) begin  // Rising toggle
          col         <= (col == col_t'(NUM_COLS - 1)) ? '0 : col + 1'b1;
          col_advance <= 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Strobe marks the first high cycle of sclk and nothing else
  a_adv_on_rise: assert property (
    @(posedge clk) disable iff (!rst_n)
    col_advance |-> (sclk && !$past(sclk))
  ) else $error("shift_clock_gen: col_advance without sclk rise");

endmodule

`default_nettype wire

// File: hub75_scan/hub75_scan.sv
`default_nettype none

module hub75_scan (
  input  logic                 clk,
  input  logic                 rst_n,
  input  panel_pkg::col_t      col,
  input  logic                 col_advance,
  output panel_pkg::fb_addr_t  rd_addr,
  input  color_pkg::rgb888_t   rd_data,
  output panel_pkg::scan_row_t addr,
  output color_pkg::rgb_bits_t rgb_top,
  output color_pkg::rgb_bits_t rgb_bottom,
  output logic                 lat
);

  import panel_pkg::*;
  import color_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LATCH,
    READ_TOP,
    READ_BOTTOM,
    CAPTURE
  } state_t;

  state_t     state;
  state_t     state_next;
  phase_t     phase;
  scan_row_t  scan_row;
  pwm_level_t level;
  rgb_bits_t  px_bits;

  assign scan_row = scan_row_t'(phase);
  assign level    = pwm_level_t'(phase >> $bits(scan_row_t));

  // Bottom half lives at the upper half of the buffer
  assign rd_addr = fb_addr_t'({state == READ_BOTTOM, scan_row, col});

  assign px_bits = pwm_bits(rd_data, level);

  // Panel shows the rows latched during the previous pass
  assign addr = scan_row_t'((int'(scan_row) + NUM_SCAN_ROWS - 1) % NUM_SCAN_ROWS);

  assign lat = (state == LATCH);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (col_advance) begin
          // Wrap to column 0 ends a pass
          state_next = (col == '0) ? LATCH : READ_TOP;
        end
      end
      LATCH:       state_next = READ_TOP;
      READ_TOP:    state_next = READ_BOTTOM;
      READ_BOTTOM: state_next = CAPTURE;
      CAPTURE:     state_next = IDLE;
      default:     state_next = IDLE;
    endcase
  end

  // Comes out of reset already fetching column 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= READ_TOP;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (state == LATCH) begin
      phase <= phase + 1'b1;  // Next scan row, PWM level every 8th
    end
  end

  // rd_data holds the top pixel in READ_BOTTOM and the bottom one in CAPTURE
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb_top    <= '0;
      rgb_bottom <= '0;
    end else begin
      if (state == READ_BOTTOM) begin
        rgb_top <= px_bits;
      end
      if (state == CAPTURE) begin
        rgb_bottom <= px_bits;
      end
    end
  end

  a_lat_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    lat |=> !lat
  ) else $error("hub75_scan: lat held for more than one cycle");

  // Shift clock must leave room for the whole fetch
  a_adv_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    col_advance |-> (state == IDLE)
  ) else $error("hub75_scan: col_advance in state %s", state.name());

endmodule

`default_nettype wire

// File: verilog/led_panel_top.sv
`default_nettype none

module led_panel_top #(
  parameter int CLK_DIV = 6
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  panel_pkg::pixel_write_t pixel_wr,
  output panel_pkg::hub75_t       panel
);

  import panel_pkg::*;
  import color_pkg::*;

  logic      sclk;
  col_t      col;
  logic      col_advance;
  fb_addr_t  wr_addr;
  fb_addr_t  rd_addr;
  rgb888_t   rd_data;
  scan_row_t scan_addr;
  rgb_bits_t rgb_top;
  rgb_bits_t rgb_bottom;
  logic      lat;

  // Row bit 3 picks the half, bits 2:0 the scan row
  assign wr_addr = fb_addr_t'({pixel_wr.row, pixel_wr.col});

  frame_buffer u_fb (
    .clk     (clk),
    .wr_en   (pixel_wr.write),
    .wr_addr (wr_addr),
    .wr_data (pixel_wr.color),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  shift_clock_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_sclk (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .col         (col),
    .col_advance (col_advance)
  );

  hub75_scan u_scan (
    .clk         (clk),
    .rst_n       (rst_n),
    .col         (col),
    .col_advance (col_advance),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .addr        (scan_addr),
    .rgb_top     (rgb_top),
    .rgb_bottom  (rgb_bottom),
    .lat         (lat)
  );

  assign panel = '{
    addr:       scan_addr,
    rgb_top:    rgb_top,
    rgb_bottom: rgb_bottom,
    lat:        lat,
    sclk:       sclk
  };

endmodule

`default_nettype wire

// File: tb/panel_monitor.sv
`default_nettype none

module panel_monitor #(
  parameter int CLK_DIV = 6
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  panel_pkg::pixel_write_t pixel_wr,
  input  panel_pkg::hub75_t       panel,
  output panel_pkg::phase_t       phase,
  output int                      rises,
  output int                      latches,
  output int                      errors
);

  timeunit 1ns;
  timeprecision 1ps;

  import panel_pkg::*;
  import color_pkg::*;

  rgb888_t    image [16][NUM_COLS];  // Indexed by panel row, then column
  int         pass_rises;            // sclk rises since the last lat
  int         run_len;
  logic       sclk_q;
  scan_row_t  addr_q;
  logic       first_rise_seen;
  logic       rise;
  scan_row_t  scan_row;
  pwm_level_t level;
  rgb_bits_t  exp_top;
  rgb_bits_t  exp_bottom;

  function automatic logic channel_on(intensity_t value, pwm_level_t lvl);
    return lvl < value;
  endfunction

  function automatic rgb_bits_t expected_bits(rgb888_t px, pwm_level_t lvl);
    rgb_bits_t bits;
    bits.r = channel_on(px.red, lvl);
    bits.g = channel_on(px.green, lvl);
    bits.b = channel_on(px.blue, lvl);
    return bits;
  endfunction

  assign rise     = panel.sclk && !sclk_q;
  assign scan_row = phase[2:0];
  assign level    = phase[10:3];

  // Bits on the port at a rise belong to the column before it
  assign exp_top    = expected_bits(image[{1'b0, scan_row}][col_t'(pass_rises)], level);
  assign exp_bottom = expected_bits(image[{1'b1, scan_row}][col_t'(pass_rises)], level);

  initial errors = 0;

  always @(posedge clk) begin
    if (pixel_wr.write) begin
      image[pixel_wr.row][pixel_wr.col] <= pixel_wr.color;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase           <= '0;
      rises           <= 0;
      latches         <= 0;
      pass_rises      <= 0;
      run_len         <= 0;
      sclk_q          <= 1'b0;
      addr_q          <= '0;
      first_rise_seen <= 1'b0;
    end else begin
      sclk_q  <= panel.sclk;
      addr_q  <= panel.addr;
      run_len <= (panel.sclk != sclk_q) ? 1 : run_len + 1;
      if (rise) begin
        a_rgb_top: assert (panel.rgb_top == exp_top) else begin
          errors++;
          $display("error %0t: panel.rgb_top got %b expected %b (phase %0d, column %0d)",
                   $time, panel.rgb_top, exp_top, phase, pass_rises);
        end
        a_rgb_bottom: assert (panel.rgb_bottom == exp_bottom) else begin
          errors++;
          $display("error %0t: panel.rgb_bottom got %b expected %b (phase %0d, column %0d)",
                   $time, panel.rgb_bottom, exp_bottom, phase, pass_rises);
        end
        first_rise_seen <= 1'b1;
        rises           <= rises + 1;
        pass_rises      <= pass_rises + 1;
      end
      if (panel.lat) begin
        a_lat_rises: assert (pass_rises == NUM_COLS) else begin
          errors++;
          $display("error %0t: sclk rises per pass got %0d expected %0d",
                   $time, pass_rises, NUM_COLS);
        end
        a_lat_sclk: assert (panel.sclk) else begin
          errors++;
          $display("error %0t: panel.sclk during lat got 0 expected 1", $time);
        end
        a_lat_addr: assert (panel.addr == scan_row_t'(scan_row - 1'b1)) else begin
          errors++;
          $display("error %0t: panel.addr during lat got %0d expected %0d",
                   $time, panel.addr, scan_row_t'(scan_row - 1'b1));
        end
        phase      <= phase + 1'b1;
        latches    <= latches + 1;
        pass_rises <= 0;
      end
    end
  end

  a_reset_quiet: assert property (
    @(posedge clk) !rst_n |-> (!panel.lat && !panel.sclk && panel.rgb_top == '0 &&
                               panel.rgb_bottom == '0)
  ) else begin
    errors++;
    $display("error %0t: panel in reset got lat %b sclk %b rgb %b/%b expected all 0",
             $time, $sampled(panel.lat), $sampled(panel.sclk),
             $sampled(panel.rgb_top), $sampled(panel.rgb_bottom));
  end

  a_no_early_lat: assert property (
    @(posedge clk) disable iff (!rst_n) !first_rise_seen |-> !panel.lat
  ) else begin
    errors++;
    $display("lat pulsed at %0t before the first shift clock edge", $time);
  end

  a_sclk_time: assert property (
    @(posedge clk) disable iff (!rst_n)
    (panel.sclk != sclk_q && first_rise_seen) |-> run_len == CLK_DIV
  ) else begin
    errors++;
    $display("error %0t: sclk level time got %0d expected %0d",
             $time, $sampled(run_len), CLK_DIV);
  end

  a_lat_single: assert property (
    @(posedge clk) disable iff (!rst_n) panel.lat |=> !panel.lat
  ) else begin
    errors++;
    $display("lat stayed high for more than one cycle at %0t", $time);
  end

  a_addr_step: assert property (
    @(posedge clk) disable iff (!rst_n) panel.lat |=> panel.addr == scan_row_t'(addr_q + 1'b1)
  ) else begin
    errors++;
    $display("error %0t: panel.addr after lat got %0d expected %0d",
             $time, $sampled(panel.addr), scan_row_t'($sampled(addr_q) + 1'b1));
  end

endmodule

`default_nettype wire

// File: tb/tb_led_panel.sv
`default_nettype none

module tb_led_panel;

  timeunit 1ns;
  timeprecision 1ps;

  import panel_pkg::*;
  import color_pkg::*;

  localparam int CLK_DIV     = 6;
  localparam int PASS_CYCLES = NUM_COLS * 2 * CLK_DIV;

  logic         clk;
  logic         rst_n;
  pixel_write_t pixel_wr;
  hub75_t       panel;
  phase_t       phase;
  int           rises;
  int           latches;
  int           errors;
  int           tests;
  int           rises_mark;
  int           latches_mark;
  int           errors_mark;
  rgb888_t      image [16][NUM_COLS];

  led_panel_top #(
    .CLK_DIV (CLK_DIV)
  ) u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .pixel_wr (pixel_wr),
    .panel    (panel)
  );

  panel_monitor #(
    .CLK_DIV (CLK_DIV)
  ) u_mon (
    .clk      (clk),
    .rst_n    (rst_n),
    .pixel_wr (pixel_wr),
    .panel    (panel),
    .phase    (phase),
    .rises    (rises),
    .latches  (latches),
    .errors   (errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic intensity_t random_channel();
    case ($urandom % 4)
      0:       return 8'h00;
      1:       return 8'hff;
      2:       return intensity_t'($urandom % 4);  // Near the levels a short run reaches
      default: return intensity_t'($urandom);
    endcase
  endfunction

  // Turns a channel's bit over at the given level
  function automatic intensity_t flipped(intensity_t value, pwm_level_t lvl);
    return (lvl < value) ? 8'h00 : 8'hff;
  endfunction

  task automatic build_image();
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        image[r][c] = '{red: random_channel(), green: random_channel(), blue: random_channel()};
      end
    end
    image[5][17] = '{red: 8'hff, green: 8'h00, blue: 8'h02};  // Marked pixel
  endtask

  task automatic load_image();
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        @(posedge clk);
        pixel_wr <= '{row: row_t'(r), col: col_t'(c), color: image[r][c], write: 1'b1};
      end
    end
    @(posedge clk);
    pixel_wr.write <= 1'b0;
  endtask

  task automatic write_pixel(input row_t r, input col_t c, input rgb888_t px);
    @(posedge clk);
    pixel_wr <= '{row: r, col: c, color: px, write: 1'b1};
    @(posedge clk);
    pixel_wr.write <= 1'b0;
  endtask

  task automatic abort_run(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("tests %0d, sclk rises %0d, latches %0d, errors %0d", tests, rises, latches, errors);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic wait_rises(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit  = (target - rises + 2) * 2 * CLK_DIV;
    while (rises < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (rises < target) begin
      abort_run($sformatf("sclk rise %0d", target));
    end
  endtask

  task automatic wait_latches(input int target);
    int cycles;
    int limit;
    cycles = 0;
    limit  = (target - latches + 1) * PASS_CYCLES;
    while (latches < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (latches < target) begin
      abort_run($sformatf("latch %0d", target));
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %-12s %0d sclk rises, %0d latches, %0d errors", name,
             rises - rises_mark, latches - latches_mark, errors - errors_mark);
    rises_mark   = rises;
    latches_mark = latches;
    errors_mark  = errors;
  endtask

  initial begin
    phase_t     base;
    pwm_level_t lvl;
    row_t       row;
    col_t       col;
    rgb888_t    new_px;
    int         mark;
    rst_n        = 1'b0;
    pixel_wr     = '0;
    tests        = 0;
    rises_mark   = 0;
    latches_mark = 0;
    errors_mark  = 0;
    void'($urandom(32'hd503));

    // Image goes in while the scan logic is held in reset
    build_image();
    load_image();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    wait_rises(1);
    finish_test("reset_quiet");

    wait_latches(24);  // Three PWM levels over all scan rows
    finish_test("scan_passes");

    // Rewrite a pixel on the row four passes ahead, so no fetch of it is in flight
    wait_latches(latches + 1);
    mark   = latches;
    base   = phase + phase_t'(4);
    lvl    = pwm_level_t'(base >> 3);
    row    = row_t'({1'($urandom), scan_row_t'(base)});
    col    = col_t'($urandom);
    new_px = '{red:   flipped(image[row][col].red, lvl),
               green: flipped(image[row][col].green, lvl),
               blue:  flipped(image[row][col].blue, lvl)};
    image[row][col] = new_px;
    write_pixel(row, col, new_px);
    wait_latches(mark + 5);
    repeat (2) @(posedge clk);
    finish_test("late_write");

    $display("tests %0d, sclk rises %0d, latches %0d, errors %0d", tests, rises, latches, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: led_panel_top.f
common/color_pkg.sv
common/panel_pkg.sv
verilog/frame_buffer.sv
hub75_scan/shift_clock_gen.sv
hub75_scan/hub75_scan.sv
verilog/led_panel_top.sv
tb/panel_monitor.sv
tb/tb_led_panel.sv

// File: Bender.yml
package:
  name: led_panel

sources:
  # Packages first, panel_pkg uses color_pkg
  - common/color_pkg.sv
  - common/panel_pkg.sv
  - verilog/frame_buffer.sv
  - hub75_scan/shift_clock_gen.sv
  - hub75_scan/hub75_scan.sv
  - verilog/led_panel_top.sv
  - target: test
    files:
      - tb/panel_monitor.sv
      - tb/tb_led_panel.sv
